// ==== filelist.f ====
+incdir+hw
hw/pipe_ctrl_pkg.sv
hw/fwd_arbiter.sv
hw/hazard_control.sv
hw/trap_csr_regs.sv
hw/pipe_ctrl_top.sv
sim/tb_pipe_ctrl.sv

// ==== hw/fwd_arbiter.sv ====
`timescale 1ns/10ps
`include "pipe_ctrl_macros.svh"

module fwd_arbiter (
    input  pipe_ctrl_pkg::id_stage_s  id,
    input  pipe_ctrl_pkg::ex_stage_s  ex,
    input  pipe_ctrl_pkg::mem_stage_s mem,
    input  pipe_ctrl_pkg::wb_stage_s  wb,
    output pipe_ctrl_pkg::fwd_sel_e   rs1_sel,
    output pipe_ctrl_pkg::fwd_sel_e   rs2_sel
);

    logic ex_fwd_ok;
    logic mem_fwd_ok;
    logic wb_fwd_ok;

    // A load in EX has no data yet; the stall covers it.
    assign ex_fwd_ok  = ex.reg_wen && (ex.rd != '0) && !ex.mem_ren;
    assign mem_fwd_ok = mem.reg_wen && (mem.rd != '0);
    assign wb_fwd_ok  = wb.reg_wen && (wb.rd != '0);

    // Youngest writer wins.
    function automatic pipe_ctrl_pkg::fwd_sel_e pick_source(
        input logic [`PC_REGW-1:0] rs
    );
        pipe_ctrl_pkg::fwd_sel_e sel;
        if (ex_fwd_ok && (ex.rd == rs)) begin
            sel = pipe_ctrl_pkg::ex_result;
        end else if (mem_fwd_ok && (mem.rd == rs)) begin
            if (mem.mem_ren) begin
                sel = pipe_ctrl_pkg::mem_rdata;
            end else begin
                sel = pipe_ctrl_pkg::mem_ex_result;
            end
        end else if (wb_fwd_ok && (wb.rd == rs)) begin
            sel = pipe_ctrl_pkg::wb_value;
        end else begin
            sel = pipe_ctrl_pkg::reg_file;
        end
        return sel;
    endfunction

    always_comb begin
        rs1_sel = pick_source(id.rs1);
        rs2_sel = pick_source(id.rs2);
    end

    // Load result in EX must never be picked up as EX forward.
    always_comb begin
        if (ex.mem_ren) begin
            assert ((rs1_sel != pipe_ctrl_pkg::ex_result)
                    && (rs2_sel != pipe_ctrl_pkg::ex_result))
                else $error("fwd_arbiter: load in EX selected as forward source");
        end
    end

endmodule

// ==== hw/hazard_control.sv ====
`timescale 1ns/10ps
`include "pipe_ctrl_macros.svh"

module hazard_control (
    input  pipe_ctrl_pkg::id_stage_s  id,
    input  pipe_ctrl_pkg::ex_stage_s  ex,
    input  pipe_ctrl_pkg::mem_stage_s mem,
    input  pipe_ctrl_pkg::wb_stage_s  wb,
    input  pipe_ctrl_pkg::fwd_sel_e   rs1_sel,
    input  pipe_ctrl_pkg::fwd_sel_e   rs2_sel,
    input  logic [`PC_XLEN-1:0]       mtvec,
    input  logic [`PC_XLEN-1:0]       mepc,
    output pipe_ctrl_pkg::ctrl_out_s  ctrl
);

    logic                load_use;
    logic                redirect;
    logic [`PC_XLEN-1:0] branch_target;

    function automatic logic [`PC_XLEN-1:0] fwd_mux(
        input pipe_ctrl_pkg::fwd_sel_e sel,
        input logic [`PC_XLEN-1:0]     reg_value
    );
        logic [`PC_XLEN-1:0] value;
        case (sel)
            pipe_ctrl_pkg::ex_result:     value = ex.result;
            pipe_ctrl_pkg::wb_value:      value = wb.rd_value;
            pipe_ctrl_pkg::mem_rdata:     value = mem.rdata;
            pipe_ctrl_pkg::mem_ex_result: value = mem.ex_result;
            default:                      value = reg_value;
        endcase
        return value;
    endfunction

    // Load in EX feeding an operand in ID.
    assign load_use = ex.mem_ren && ex.reg_wen && (ex.rd != '0)
                      && ((ex.rd == id.rs1) || (ex.rd == id.rs2));

    assign redirect = ex.jump || ex.branch || ex.mret || ex.ecall;

    // Nonzero EX result means the branch is taken.
    assign branch_target = (ex.result != '0) ? (ex.pc + ex.imm)
                                             : (ex.pc + `PC_XLEN'd4);

    always_comb begin
        ctrl.rs1_fwd  = fwd_mux(rs1_sel, id.rs1_value);
        ctrl.rs2_fwd  = fwd_mux(rs2_sel, id.rs2_value);

        ctrl.if_stall = load_use;
        ctrl.id_stall = load_use;
        ctrl.id_flush = redirect;
        ctrl.ex_flush = ex.jump || ex.branch || load_use;

        if (ex.jump) begin
            ctrl.dnpc = ex.result;
        end else if (ex.branch) begin
            ctrl.dnpc = branch_target;
        end else if (ex.mret) begin
            ctrl.dnpc = mepc;
        end else if (ex.ecall) begin
            ctrl.dnpc = mtvec;
        end else begin
            ctrl.dnpc = '0;
        end
        ctrl.dnpc_valid = redirect;
    end

    // Decode delivers at most one control transfer per instruction.
    always_comb begin
        assert ($onehot0({ex.jump, ex.branch, ex.mret, ex.ecall}))
            else $error("hazard_control: more than one redirect flag set in EX");
    end

endmodule

// ==== hw/pipe_ctrl_macros.svh ====
`ifndef PIPE_CTRL_MACROS_SVH
`define PIPE_CTRL_MACROS_SVH

// Datapath and register index widths.
`define PC_XLEN 32
`define PC_REGW 5

// CSR offsets on the AXI4-Lite port.
`define PC_CSR_MTVEC  4'h0
`define PC_CSR_MEPC   4'h4
`define PC_CSR_STALLS 4'h8
`define PC_CSR_REDIRS 4'hC

// Trap vector base.
// Return address, written by ecall capture.
// Counters are read-only.

`endif

// ==== hw/pipe_ctrl_pkg.sv ====
`include "pipe_ctrl_macros.svh"

package pipe_ctrl_pkg;

    // Operand source for the EX stage.
    typedef enum logic [2:0] {
        reg_file      = 3'b000,
        ex_result     = 3'b001,
        wb_value      = 3'b010,
        mem_rdata     = 3'b011,
        mem_ex_result = 3'b100
    } fwd_sel_e;

    typedef struct packed {
        logic [`PC_REGW-1:0] rs1;
        logic [`PC_REGW-1:0] rs2;
        logic [`PC_XLEN-1:0] rs1_value;
        logic [`PC_XLEN-1:0] rs2_value;
    } id_stage_s;

    typedef struct packed {
        logic [`PC_XLEN-1:0] pc;
        logic [`PC_XLEN-1:0] imm;
        logic [`PC_XLEN-1:0] result;
        logic [`PC_REGW-1:0] rd;
        logic                reg_wen;
        logic                mem_ren;
        logic                branch;
        logic                jump;
        logic                mret;
        logic                ecall;
    } ex_stage_s;

    typedef struct packed {
        logic [`PC_XLEN-1:0] ex_result;
        logic [`PC_XLEN-1:0] rdata;
        logic [`PC_REGW-1:0] rd;
        logic                reg_wen;
        logic                mem_ren;
    } mem_stage_s;

    typedef struct packed {
        logic [`PC_XLEN-1:0] rd_value;
        logic [`PC_REGW-1:0] rd;
        logic                reg_wen;
    } wb_stage_s;

    typedef struct packed {
        logic [`PC_XLEN-1:0] rs1_fwd;
        logic [`PC_XLEN-1:0] rs2_fwd;
        logic                if_stall;
        logic                id_stall;
        logic                id_flush;
        logic                ex_flush;
        logic [`PC_XLEN-1:0] dnpc;
        logic                dnpc_valid;
    } ctrl_out_s;

    // Master to slave.
    typedef struct packed {
        logic [3:0]          awaddr;
        logic                awvalid;
        logic [`PC_XLEN-1:0] wdata;
        logic                wvalid;
        logic                bready;
        logic [3:0]          araddr;
        logic                arvalid;
        logic                rready;
    } axil_req_s;

    // Slave to master.
    typedef struct packed {
        logic                awready;
        logic                wready;
        logic [1:0]          bresp;
        logic                bvalid;
        logic                arready;
        logic [`PC_XLEN-1:0] rdata;
        logic [1:0]          rresp;
        logic                rvalid;
    } axil_rsp_s;

endpackage

// ==== hw/pipe_ctrl_top.sv ====
`timescale 1ns/10ps
`include "pipe_ctrl_macros.svh"

module pipe_ctrl_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  pipe_ctrl_pkg::id_stage_s  id,
    input  pipe_ctrl_pkg::ex_stage_s  ex,
    input  pipe_ctrl_pkg::mem_stage_s mem,
    input  pipe_ctrl_pkg::wb_stage_s  wb,
    output pipe_ctrl_pkg::ctrl_out_s  ctrl,
    input  pipe_ctrl_pkg::axil_req_s  axil_req,
    output pipe_ctrl_pkg::axil_rsp_s  axil_rsp
);

    pipe_ctrl_pkg::fwd_sel_e rs1_sel;
    pipe_ctrl_pkg::fwd_sel_e rs2_sel;
    logic [`PC_XLEN-1:0]     mtvec;
    logic [`PC_XLEN-1:0]     mepc;

    fwd_arbiter u_fwd_arbiter (
        .id      (id),
        .ex      (ex),
        .mem     (mem),
        .wb      (wb),
        .rs1_sel (rs1_sel),
        .rs2_sel (rs2_sel)
    );

    hazard_control u_hazard_control (
        .id      (id),
        .ex      (ex),
        .mem     (mem),
        .wb      (wb),
        .rs1_sel (rs1_sel),
        .rs2_sel (rs2_sel),
        .mtvec   (mtvec),
        .mepc    (mepc),
        .ctrl    (ctrl)
    );

    // Counters sample the stall and redirect seen by the pipeline.
    trap_csr_regs u_trap_csr_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .stall    (ctrl.if_stall),
        .redirect (ctrl.dnpc_valid),
        .ecall    (ex.ecall),
        .ex_pc    (ex.pc),
        .mtvec    (mtvec),
        .mepc     (mepc)
    );

endmodule

// ==== hw/trap_csr_regs.sv ====
`timescale 1ns/10ps
`include "pipe_ctrl_macros.svh"

module trap_csr_regs (
    input  logic                     clk,
    input  logic                     arst_n,
    input  pipe_ctrl_pkg::axil_req_s axil_req,
    output pipe_ctrl_pkg::axil_rsp_s axil_rsp,
    input  logic                     stall,
    input  logic                     redirect,
    input  logic                     ecall,
    input  logic [`PC_XLEN-1:0]      ex_pc,
    output logic [`PC_XLEN-1:0]      mtvec,
    output logic [`PC_XLEN-1:0]      mepc
);

    logic                wr_ready;
    logic                bvalid;
    logic                rd_ready;
    logic                rvalid;
    logic [`PC_XLEN-1:0] rdata;
    logic [`PC_XLEN-1:0] rd_value;
    logic [`PC_XLEN-1:0] stall_cnt;
    logic [`PC_XLEN-1:0] redir_cnt;
    logic                wr_start;
    logic                wr_fire;
    logic                rd_start;
    logic                rd_fire;

    // Pending response blocks a new transaction of the same kind.
    assign wr_start = axil_req.awvalid && axil_req.wvalid && !wr_ready && !bvalid;
    assign wr_fire  = axil_req.awvalid && axil_req.wvalid && wr_ready;
    assign rd_start = axil_req.arvalid && !rd_ready && !rvalid;
    assign rd_fire  = axil_req.arvalid && rd_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            wr_ready <= wr_start;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ready <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            rd_ready <= rd_start;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (axil_req.araddr)
            `PC_CSR_MTVEC:  rd_value = mtvec;
            `PC_CSR_MEPC:   rd_value = mepc;
            `PC_CSR_STALLS: rd_value = stall_cnt;
            `PC_CSR_REDIRS: rd_value = redir_cnt;
            default:        rd_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_value;
        end
    end

    // Ecall capture wins over a software write to mepc.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtvec     <= '0;
            mepc      <= '0;
            stall_cnt <= '0;
            redir_cnt <= '0;
        end else begin
            if (wr_fire && (axil_req.awaddr == `PC_CSR_MTVEC)) begin
                mtvec <= axil_req.wdata;
            end
            if (ecall) begin
                mepc <= ex_pc;
            end else if (wr_fire && (axil_req.awaddr == `PC_CSR_MEPC)) begin
                mepc <= axil_req.wdata;
            end
            if (stall) begin
                stall_cnt <= stall_cnt + 1'b1;
            end
            if (redirect) begin
                redir_cnt <= redir_cnt + 1'b1;
            end
        end
    end

    assign axil_rsp.awready = wr_ready;
    assign axil_rsp.wready  = wr_ready;
    assign axil_rsp.bresp   = 2'b00;
    assign axil_rsp.bvalid  = bvalid;
    assign axil_rsp.arready = rd_ready;
    assign axil_rsp.rdata   = rdata;
    assign axil_rsp.rresp   = 2'b00;
    assign axil_rsp.rvalid  = rvalid;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !axil_req.bready |=> bvalid);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the pipeline control testbench with Verilator.
set -e

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pipe_ctrl -f filelist.f -o sim_pipe_ctrl

./obj_dir/sim_pipe_ctrl 2>&1 | tee "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "Simulation ended without a result line, see $LOG"
    exit 1
fi
echo "Simulation finished cleanly"

// ==== sim/pipe_ctrl_testdata.txt ====
# V id: rs1 rs2 rs1_value rs2_value  ex: pc imm result rd wen.ren.branch.jump.mret.ecall
#   mem: ex_result rdata rd wen.ren  wb: rd_value rd wen
#   expected: rs1_fwd rs2_fwd if_stall.id_stall.id_flush.ex_flush.dnpc_valid dnpc
# W offset data / R offset expected_data; values hex, flag groups binary
# forwarding priority
V 5 6 a0 b0 100 0 11 5 100000 22 44 5 10 33 5 1 11 b0 00000 0
V 5 5 a0 b0 104 0 11 7 100000 22 44 5 10 33 5 1 22 22 00000 0
V 5 6 a0 b0 108 0 11 7 100000 22 44 5 11 33 6 1 44 33 00000 0
V 6 9 a0 b0 10c 0 11 7 100000 22 44 5 10 33 6 1 33 b0 00000 0
V 0 0 a0 b0 110 0 11 0 100000 22 44 0 11 33 0 1 a0 b0 00000 0
V 5 6 a0 b0 114 0 11 5 000000 22 44 5 10 33 6 0 22 b0 00000 0
# load-use
V 5 3 a0 b0 118 0 0 5 110000 0 0 0 00 0 0 0 a0 b0 11010 0
V 3 8 a0 b0 11c 0 0 8 110000 0 0 0 00 0 0 0 a0 b0 11010 0
V 0 0 a0 b0 120 0 0 0 110000 0 0 0 00 0 0 0 a0 b0 00000 0
# branch and jump
V 1 2 a0 b0 200 40 1 0 001000 0 0 0 00 0 0 0 a0 b0 00111 240
V 1 2 a0 b0 200 fffffff0 1 0 001000 0 0 0 00 0 0 0 a0 b0 00111 1f0
V 1 2 a0 b0 200 40 0 0 001000 0 0 0 00 0 0 0 a0 b0 00111 204
V 1 2 a0 b0 300 0 3000 4 100100 0 0 0 00 0 0 0 a0 b0 00111 3000
# CSR access
W 0 400
R 0 400
R 4 0
W 8 dead
R 8 2
R 6 0
# trap flow
V 1 2 a0 b0 1234 0 0 0 000001 0 0 0 00 0 0 0 a0 b0 00101 400
R 4 1234
V 1 2 a0 b0 500 0 0 0 000010 0 0 0 00 0 0 0 a0 b0 00101 1234
# counters
W c 7
R 8 2
R c 6

// ==== sim/tb_pipe_ctrl.sv ====
`timescale 1ns/10ps
`include "pipe_ctrl_macros.svh"

module tb_pipe_ctrl;

    localparam int    CLK_PERIOD = 40;
    localparam int    DRIVE_DLY  = 2;
    localparam int    N_FIELDS   = 20;
    localparam string DATA_FILE  = "sim/pipe_ctrl_testdata.txt";

    logic                      clk;
    logic                      arst_n;
    pipe_ctrl_pkg::id_stage_s  id;
    pipe_ctrl_pkg::ex_stage_s  ex;
    pipe_ctrl_pkg::mem_stage_s mem;
    pipe_ctrl_pkg::wb_stage_s  wb;
    pipe_ctrl_pkg::ctrl_out_s  ctrl;
    pipe_ctrl_pkg::axil_req_s  axil_req;
    pipe_ctrl_pkg::axil_rsp_s  axil_rsp;

    logic [31:0] fld [N_FIELDS];
    int          fd;
    int          line_count = 0;
    int          test_count = 0;
    int          err_count = 0;
    int          stall_tally = 0;
    int          redir_tally = 0;
    bit          test_ok;

    pipe_ctrl_top u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .id       (id),
        .ex       (ex),
        .mem      (mem),
        .wb       (wb),
        .ctrl     (ctrl),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Roughly ten cycles per record, plus reset and margin.
    initial begin
        wait (arst_n === 1'b1);
        repeat (line_count * 10 + 100) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", line_count * 10 + 100);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_ctrl(input pipe_ctrl_pkg::ctrl_out_s got,
                              input pipe_ctrl_pkg::ctrl_out_s exp);
        if (got !== exp) begin
            $display("Error at %0t: ctrl got %h %h %b %h, expected %h %h %b %h",
                     $time, got.rs1_fwd, got.rs2_fwd,
                     {got.if_stall, got.id_stall, got.id_flush, got.ex_flush, got.dnpc_valid},
                     got.dnpc, exp.rs1_fwd, exp.rs2_fwd,
                     {exp.if_stall, exp.id_stall, exp.id_flush, exp.ex_flush, exp.dnpc_valid},
                     exp.dnpc);
            err_count++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_rdata(input logic [`PC_XLEN-1:0] got, input logic [`PC_XLEN-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s read %h, expected %h", $time, what, got, exp);
            err_count++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input string what);
        if (got !== 2'b00) begin
            $display("Error at %0t: %s is %b, expected OKAY", $time, what, got);
            err_count++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_ready(input logic got, input string what);
        if (got !== 1'b1) begin
            $display("Error at %0t: %s is %b, expected 1", $time, what, got);
            err_count++;
            test_ok = 1'b0;
        end
    endtask

    task automatic drive_idle();
        id  = '0;
        ex  = '0;
        mem = '0;
        wb  = '0;
    endtask

    task automatic report_test(input string what);
        test_count++;
        $display("test %0d %s: %s", test_count, what, test_ok ? "ok" : "mismatch");
    endtask

    task automatic apply_vector();
        pipe_ctrl_pkg::ctrl_out_s exp;
        @(posedge clk);
        #DRIVE_DLY;
        id  = {fld[0][4:0], fld[1][4:0], fld[2], fld[3]};
        ex  = {fld[4], fld[5], fld[6], fld[7][4:0], fld[8][5:0]};
        mem = {fld[9], fld[10], fld[11][4:0], fld[12][1:0]};
        wb  = {fld[13], fld[14][4:0], fld[15][0]};
        exp = {fld[16], fld[17], fld[18][4:1], fld[19], fld[18][0]};
        #(CLK_PERIOD - DRIVE_DLY - 1);
        check_ctrl(ctrl, exp);
        // Counters see this vector on the coming edge.
        stall_tally += int'(exp.if_stall);
        redir_tally += int'(exp.dnpc_valid);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [`PC_XLEN-1:0] data);
        @(posedge clk);
        #DRIVE_DLY;
        drive_idle();
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
        end while (!axil_rsp.awready && !axil_rsp.wready);
        check_ready(axil_rsp.awready, "awready");
        check_ready(axil_rsp.wready, "wready");
        // Address and data are taken on the next edge.
        @(posedge clk);
        #DRIVE_DLY;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        check_resp(axil_rsp.bresp, "bresp");
        @(posedge clk);
        #DRIVE_DLY;
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [`PC_XLEN-1:0] data);
        @(posedge clk);
        #DRIVE_DLY;
        drive_idle();
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
        end while (!axil_rsp.arready);
        @(posedge clk);
        #DRIVE_DLY;
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        check_resp(axil_rsp.rresp, "rresp");
        data = axil_rsp.rdata;
        @(posedge clk);
        #DRIVE_DLY;
        axil_req.rready = 1'b0;
    endtask

    initial begin
        logic [7:0]          kind;
        logic [3:0]          addr;
        logic [`PC_XLEN-1:0] data;
        logic [`PC_XLEN-1:0] got;
        logic [8*160-1:0]    line_buf;
        int                  code;
        arst_n   = 1'b0;
        axil_req = '0;
        drive_idle();
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open stimulus file %s", DATA_FILE);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line_buf, fd);
                if (code > 0) begin
                    line_count++;
                end
            end
            $fclose(fd);
            fd = $fopen(DATA_FILE, "r");
            repeat (2) @(posedge clk);
            #DRIVE_DLY;
            arst_n = 1'b1;

            code = $fscanf(fd, " %c", kind);
            while (code == 1) begin
                test_ok = 1'b1;
                case (kind)
                    "#": code = $fgets(line_buf, fd);
                    "V": begin
                        code = $fscanf(fd,
                            "%h %h %h %h %h %h %h %h %b %h %h %h %b %h %h %b %h %h %b %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                            fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                            fld[14], fld[15], fld[16], fld[17], fld[18], fld[19]);
                        if (code != N_FIELDS) begin
                            $display("Malformed vector record after test %0d", test_count);
                            err_count++;
                        end else begin
                            apply_vector();
                            report_test("vector");
                        end
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        axi_write(addr, data);
                        report_test($sformatf("write %h", addr));
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        axi_read(addr, got);
                        check_rdata(got, data, "csr");
                        if (addr == `PC_CSR_STALLS) begin
                            check_rdata(got, 32'(stall_tally), "stall counter");
                        end else if (addr == `PC_CSR_REDIRS) begin
                            check_rdata(got, 32'(redir_tally), "redirect counter");
                        end
                        report_test($sformatf("read %h", addr));
                    end
                    default: begin
                        $display("Unknown record kind after test %0d", test_count);
                        err_count++;
                        code = $fgets(line_buf, fd);
                    end
                endcase
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);

            $display("%0d tests run, %0d errors", test_count, err_count);
            if (err_count == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule
